//--- src/adxl_i2c_pkg.sv
// adxl i2c master shared types
package adxl_i2c_pkg;

	localparam int ADDR_W = 7;
	localparam int BURST_BYTES = 11;

	// first register of the burst
	localparam logic [7:0] REG_TEMP2 = 8'h06;

	typedef enum logic [1:0] {
		OP_RREG = 2'd0,
		OP_WREG = 2'd1,
		OP_HW   = 2'd2
	} op_t;

	// quarter-bit period is 2^(rate+2) clocks
	typedef enum logic [1:0] {
		RATE_3125K = 2'd0,
		RATE_1562K = 2'd1,
		RATE_781K  = 2'd2,
		RATE_390K  = 2'd3
	} rate_t;

	typedef enum logic [1:0] {
		BK_START = 2'd0,
		BK_WRITE = 2'd1,
		BK_READ  = 2'd2,
		BK_STOP  = 2'd3
	} byte_kind_t;

	typedef enum logic [3:0] {
		SQ_IDLE,
		SQ_START,
		SQ_ADDR_W,
		SQ_POINTER,
		SQ_WDATA,
		SQ_STOP_SET,
		SQ_RESTART,
		SQ_ADDR_R,
		SQ_READ,
		SQ_STOP
	} seq_state_t;

	typedef struct packed {
		byte_kind_t kind;
		logic [7:0] data;
		// nack after a read byte
		logic       ack_last;
		logic [3:0] slot;
	} byte_cmd_t;

	typedef struct packed {
		logic [7:0] data;
		logic       nack;
		logic [3:0] slot;
	} byte_rsp_t;

	typedef struct packed {
		op_t  op;
		logic ok;
	} txn_end_t;

	typedef struct packed {
		logic [31:0] temp;
		logic [31:0] accx;
		logic [31:0] accy;
		logic [31:0] accz;
	} sample_t;

endpackage

//--- src/i2c_bit_timer.sv
// i2c quarter-bit tick generator
`timescale 1ns/1ps

module i2c_bit_timer (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  adxl_i2c_pkg::rate_t i_rate,
	input  logic                i_run,
	output logic                o_tick
);

	adxl_i2c_pkg::rate_t rate_q;
	logic [4:0] cnt;
	logic [4:0] last;

	always_comb begin
		case (rate_q)
			adxl_i2c_pkg::RATE_3125K: last = 5'd3;
			adxl_i2c_pkg::RATE_1562K: last = 5'd7;
			adxl_i2c_pkg::RATE_781K:  last = 5'd15;
			default:                  last = 5'd31;
		endcase
	end

	// rate only follows the input between commands
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= 5'd0;
			rate_q <= adxl_i2c_pkg::RATE_390K;
		end else if (!i_run) begin
			cnt <= 5'd0;
			rate_q <= i_rate;
		end else if (cnt == last) begin
			cnt <= 5'd0;
		end else begin
			cnt <= cnt + 5'd1;
		end
	end

	assign o_tick = i_run && (cnt == last);

endmodule

//--- src/adxl_txn_sequencer.sv
// adxl transaction sequencer
`timescale 1ns/1ps

module adxl_txn_sequencer #(
	parameter logic [adxl_i2c_pkg::ADDR_W-1:0] DEV_ADDR = 7'h1D
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_start,
	input  adxl_i2c_pkg::op_t        i_op,
	input  logic [7:0]               i_reg_addr,
	input  logic [7:0]               i_w_data,
	input  logic                     i_drdy,
	input  logic                     i_eng_busy,
	input  logic                     i_rsp_stb,
	input  adxl_i2c_pkg::byte_rsp_t  i_rsp,
	output logic                     o_cmd_stb,
	output adxl_i2c_pkg::byte_cmd_t  o_cmd,
	output logic                     o_end_stb,
	output adxl_i2c_pkg::txn_end_t   o_end,
	output logic                     o_busy,
	output logic                     o_done,
	output logic                     o_nack
);

	adxl_i2c_pkg::seq_state_t state;
	adxl_i2c_pkg::op_t op_q;
	logic [7:0] reg_q;
	logic [7:0] wdata_q;
	logic [3:0] slot;
	logic [3:0] last_slot;
	logic [1:0] drdy_sync;
	logic issued;
	logic fail_q;
	logic start_req;

	assign last_slot = (op_q == adxl_i2c_pkg::OP_HW) ? 4'(adxl_i2c_pkg::BURST_BYTES - 1) : 4'd0;
	assign o_busy = (state != adxl_i2c_pkg::SQ_IDLE);
	assign o_done = o_end_stb;
	assign o_end = '{op: op_q, ok: !fail_q};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			drdy_sync <= 2'b00;
		end else begin
			drdy_sync <= {drdy_sync[0], i_drdy};
		end
	end

	// burst follows the data-ready level, cpu ops the start strobe
	always_comb begin
		case (i_op)
			adxl_i2c_pkg::OP_HW:   start_req = drdy_sync[1];
			adxl_i2c_pkg::OP_RREG: start_req = i_start;
			adxl_i2c_pkg::OP_WREG: start_req = i_start;
			default:               start_req = 1'b0;
		endcase
	end

	always_comb begin
		o_cmd = '{kind: adxl_i2c_pkg::BK_START, data: 8'h00, ack_last: 1'b0, slot: slot};
		case (state)
			adxl_i2c_pkg::SQ_ADDR_W: begin
				o_cmd.kind = adxl_i2c_pkg::BK_WRITE;
				o_cmd.data = {DEV_ADDR, 1'b0};
			end
			adxl_i2c_pkg::SQ_POINTER: begin
				o_cmd.kind = adxl_i2c_pkg::BK_WRITE;
				o_cmd.data = (op_q == adxl_i2c_pkg::OP_HW) ? adxl_i2c_pkg::REG_TEMP2 : reg_q;
			end
			adxl_i2c_pkg::SQ_WDATA: begin
				o_cmd.kind = adxl_i2c_pkg::BK_WRITE;
				o_cmd.data = wdata_q;
			end
			adxl_i2c_pkg::SQ_ADDR_R: begin
				o_cmd.kind = adxl_i2c_pkg::BK_WRITE;
				o_cmd.data = {DEV_ADDR, 1'b1};
			end
			adxl_i2c_pkg::SQ_READ: begin
				o_cmd.kind = adxl_i2c_pkg::BK_READ;
				o_cmd.ack_last = (slot == last_slot);
			end
			adxl_i2c_pkg::SQ_STOP_SET, adxl_i2c_pkg::SQ_STOP: begin
				o_cmd.kind = adxl_i2c_pkg::BK_STOP;
			end
			default: o_cmd.kind = adxl_i2c_pkg::BK_START;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (state == adxl_i2c_pkg::SQ_IDLE && start_req) begin
			reg_q <= i_reg_addr;
			wdata_q <= i_w_data;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= adxl_i2c_pkg::SQ_IDLE;
			op_q <= adxl_i2c_pkg::OP_RREG;
			slot <= 4'd0;
			issued <= 1'b0;
			fail_q <= 1'b0;
			o_cmd_stb <= 1'b0;
			o_end_stb <= 1'b0;
			o_nack <= 1'b0;
		end else begin
			o_cmd_stb <= 1'b0;
			o_end_stb <= 1'b0;
			if (state == adxl_i2c_pkg::SQ_IDLE) begin
				if (start_req) begin
					state <= adxl_i2c_pkg::SQ_START;
					op_q <= i_op;
					slot <= 4'd0;
					fail_q <= 1'b0;
				end
			end else if (!issued) begin
				// one command per state, sent once the engine is free
				if (!i_eng_busy) begin
					o_cmd_stb <= 1'b1;
					issued <= 1'b1;
				end
			end else if (i_rsp_stb) begin
				issued <= 1'b0;
				if (i_rsp.nack)
					fail_q <= 1'b1;
				case (state)
					adxl_i2c_pkg::SQ_START: state <= adxl_i2c_pkg::SQ_ADDR_W;
					adxl_i2c_pkg::SQ_ADDR_W: begin
						state <= i_rsp.nack ? adxl_i2c_pkg::SQ_STOP : adxl_i2c_pkg::SQ_POINTER;
					end
					adxl_i2c_pkg::SQ_POINTER: begin
						if (i_rsp.nack)
							state <= adxl_i2c_pkg::SQ_STOP;
						else if (op_q == adxl_i2c_pkg::OP_WREG)
							state <= adxl_i2c_pkg::SQ_WDATA;
						else
							state <= adxl_i2c_pkg::SQ_STOP_SET;
					end
					adxl_i2c_pkg::SQ_WDATA: state <= adxl_i2c_pkg::SQ_STOP;
					adxl_i2c_pkg::SQ_STOP_SET: state <= adxl_i2c_pkg::SQ_RESTART;
					adxl_i2c_pkg::SQ_RESTART: state <= adxl_i2c_pkg::SQ_ADDR_R;
					adxl_i2c_pkg::SQ_ADDR_R: begin
						state <= i_rsp.nack ? adxl_i2c_pkg::SQ_STOP : adxl_i2c_pkg::SQ_READ;
					end
					adxl_i2c_pkg::SQ_READ: begin
						if (slot == last_slot)
							state <= adxl_i2c_pkg::SQ_STOP;
						else
							slot <= slot + 4'd1;
					end
					default: begin
						// final stop done
						state <= adxl_i2c_pkg::SQ_IDLE;
						o_end_stb <= 1'b1;
						o_nack <= fail_q;
					end
				endcase
			end
		end
	end

endmodule

//--- src/i2c_byte_engine.sv
// i2c start/stop and byte engine
`timescale 1ns/1ps

module i2c_byte_engine (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_tick,
	input  logic                     i_cmd_stb,
	input  adxl_i2c_pkg::byte_cmd_t  i_cmd,
	input  logic                     i_sda,
	output logic                     o_busy,
	output logic                     o_rsp_stb,
	output adxl_i2c_pkg::byte_rsp_t  o_rsp,
	output logic                     o_rsp_is_read,
	output logic                     o_scl_oe,
	output logic                     o_sda_oe
);

	adxl_i2c_pkg::byte_cmd_t cmd_q;
	logic [1:0] phase;
	logic [3:0] bit_cnt;
	logic [7:0] shift_q;
	logic [1:0] sda_sync;
	logic nack_q;
	logic is_byte;
	logic in_data;
	logic last_bit;

	assign is_byte = (cmd_q.kind == adxl_i2c_pkg::BK_WRITE) ||
		(cmd_q.kind == adxl_i2c_pkg::BK_READ);
	// bits 0..7 are data, bit 8 is the ack slot
	assign in_data = (bit_cnt < 4'd8);
	assign last_bit = !is_byte || (bit_cnt == 4'd8);

	assign o_rsp = '{data: shift_q, nack: nack_q, slot: cmd_q.slot};
	assign o_rsp_is_read = (cmd_q.kind == adxl_i2c_pkg::BK_READ);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sda_sync <= 2'b11;
		end else begin
			sda_sync <= {sda_sync[0], i_sda};
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cmd_q <= '0;
			phase <= 2'd0;
			bit_cnt <= 4'd0;
			nack_q <= 1'b0;
			o_busy <= 1'b0;
			o_rsp_stb <= 1'b0;
			o_scl_oe <= 1'b0;
			o_sda_oe <= 1'b0;
		end else begin
			o_rsp_stb <= 1'b0;
			if (!o_busy) begin
				if (i_cmd_stb) begin
					o_busy <= 1'b1;
					cmd_q <= i_cmd;
					phase <= 2'd0;
					bit_cnt <= 4'd0;
					nack_q <= 1'b0;
				end
			end else if (i_tick) begin
				phase <= phase + 2'd1;
				// phase 1 only holds the low half of scl
				case (phase)
					2'd0: begin
						case (cmd_q.kind)
							adxl_i2c_pkg::BK_START: o_sda_oe <= 1'b0;
							adxl_i2c_pkg::BK_STOP: begin
								o_scl_oe <= 1'b1;
								o_sda_oe <= 1'b1;
							end
							adxl_i2c_pkg::BK_WRITE: begin
								o_scl_oe <= 1'b1;
								o_sda_oe <= in_data ? ~shift_q[7] : 1'b0;
							end
							default: begin
								o_scl_oe <= 1'b1;
								o_sda_oe <= in_data ? 1'b0 : ~cmd_q.ack_last;
							end
						endcase
					end
					2'd2: begin
						// start pulls sda with scl still high
						if (cmd_q.kind == adxl_i2c_pkg::BK_START)
							o_sda_oe <= 1'b1;
						else
							o_scl_oe <= 1'b0;
						if (cmd_q.kind == adxl_i2c_pkg::BK_WRITE && !in_data)
							nack_q <= sda_sync[1];
					end
					2'd3: begin
						if (cmd_q.kind == adxl_i2c_pkg::BK_STOP)
							o_sda_oe <= 1'b0;
						if (last_bit) begin
							o_busy <= 1'b0;
							o_rsp_stb <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// msb first in both directions
	always_ff @(posedge i_clk) begin
		if (!o_busy && i_cmd_stb) begin
			shift_q <= (i_cmd.kind == adxl_i2c_pkg::BK_WRITE) ? i_cmd.data : 8'h00;
		end else if (o_busy && i_tick && in_data) begin
			if (cmd_q.kind == adxl_i2c_pkg::BK_WRITE && phase == 2'd0)
				shift_q <= {shift_q[6:0], 1'b0};
			else if (cmd_q.kind == adxl_i2c_pkg::BK_READ && phase == 2'd2)
				shift_q <= {shift_q[6:0], sda_sync[1]};
		end
	end

endmodule

//--- src/adxl_sample_assembler.sv
// adxl read byte store and sample format
`timescale 1ns/1ps

module adxl_sample_assembler (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_rsp_stb,
	input  logic                     i_rsp_is_read,
	input  adxl_i2c_pkg::byte_rsp_t  i_rsp,
	input  logic                     i_end_stb,
	input  adxl_i2c_pkg::txn_end_t   i_end,
	output logic [7:0]               o_reg_data,
	output adxl_i2c_pkg::sample_t    o_sample
);

	logic [7:0] slot_q [adxl_i2c_pkg::BURST_BYTES];

	// 20-bit left-justified axis value, sign-extended
	function automatic logic [31:0] axis_word(
		input logic [7:0] hi,
		input logic [7:0] mid,
		input logic [7:0] lo
	);
		axis_word = {{12{hi[7]}}, hi, mid, lo[7:4]};
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_rsp_stb && i_rsp_is_read && (i_rsp.slot < 4'(adxl_i2c_pkg::BURST_BYTES)))
			slot_q[i_rsp.slot] <= i_rsp.data;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_reg_data <= 8'h00;
			o_sample <= '0;
		end else if (i_end_stb && i_end.ok) begin
			if (i_end.op == adxl_i2c_pkg::OP_RREG) begin
				o_reg_data <= slot_q[0];
			end else if (i_end.op == adxl_i2c_pkg::OP_HW) begin
				// temp2 low nibble above temp1
				o_sample.temp <= {20'h00000, slot_q[0][3:0], slot_q[1]};
				o_sample.accx <= axis_word(slot_q[2], slot_q[3], slot_q[4]);
				o_sample.accy <= axis_word(slot_q[5], slot_q[6], slot_q[7]);
				o_sample.accz <= axis_word(slot_q[8], slot_q[9], slot_q[10]);
			end
		end
	end

endmodule

//--- src/adxl_i2c_top.sv
// adxl i2c master top
`timescale 1ns/1ps

module adxl_i2c_top #(
	parameter logic [adxl_i2c_pkg::ADDR_W-1:0] DEV_ADDR = 7'h1D
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_start,
	input  adxl_i2c_pkg::op_t      i_op,
	input  adxl_i2c_pkg::rate_t    i_rate,
	input  logic [7:0]             i_reg_addr,
	input  logic [7:0]             i_w_data,
	input  logic                   i_drdy,
	input  logic                   i_sda,
	output logic                   o_scl_oe,
	output logic                   o_sda_oe,
	output logic                   o_busy,
	output logic                   o_done,
	output logic                   o_nack,
	output logic [7:0]             o_reg_data,
	output adxl_i2c_pkg::sample_t  o_sample
);

	logic tick;
	logic eng_busy;
	logic cmd_stb;
	logic rsp_stb;
	logic rsp_is_read;
	logic end_stb;
	adxl_i2c_pkg::byte_cmd_t cmd;
	adxl_i2c_pkg::byte_rsp_t rsp;
	adxl_i2c_pkg::txn_end_t txn_end;

	// timer runs only while a command is on the bus
	i2c_bit_timer u_bit_timer (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rate  (i_rate),
		.i_run   (eng_busy),
		.o_tick  (tick)
	);

	adxl_txn_sequencer #(
		.DEV_ADDR (DEV_ADDR)
	) u_sequencer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_op       (i_op),
		.i_reg_addr (i_reg_addr),
		.i_w_data   (i_w_data),
		.i_drdy     (i_drdy),
		.i_eng_busy (eng_busy),
		.i_rsp_stb  (rsp_stb),
		.i_rsp      (rsp),
		.o_cmd_stb  (cmd_stb),
		.o_cmd      (cmd),
		.o_end_stb  (end_stb),
		.o_end      (txn_end),
		.o_busy     (o_busy),
		.o_done     (o_done),
		.o_nack     (o_nack)
	);

	i2c_byte_engine u_byte_engine (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_tick        (tick),
		.i_cmd_stb     (cmd_stb),
		.i_cmd         (cmd),
		.i_sda         (i_sda),
		.o_busy        (eng_busy),
		.o_rsp_stb     (rsp_stb),
		.o_rsp         (rsp),
		.o_rsp_is_read (rsp_is_read),
		.o_scl_oe      (o_scl_oe),
		.o_sda_oe      (o_sda_oe)
	);

	adxl_sample_assembler u_assembler (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rsp_stb     (rsp_stb),
		.i_rsp_is_read (rsp_is_read),
		.i_rsp         (rsp),
		.i_end_stb     (end_stb),
		.i_end         (txn_end),
		.o_reg_data    (o_reg_data),
		.o_sample      (o_sample)
	);

endmodule

//--- verif/adxl_slave_model.sv
// behavioral i2c slave
`timescale 1ns/1ps

module adxl_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h1D,
	parameter int SEED = 97363
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	input  logic i_absent,
	output logic o_sda_pull
);

	typedef enum logic [1:0] {M_IDLE, M_ADDR, M_WRITE, M_READ} mode_t;

	logic [7:0] regs [256];
	mode_t mode;
	logic [3:0] bit_cnt;
	logic [7:0] shift;
	logic [7:0] ptr;
	logic got_ptr;
	logic rd;
	logic scl_q;
	logic sda_q;
	integer seed;

	// bus is sampled on the clock so simultaneous scl and sda changes do not race
	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// register file reloads from the seed on reset
			seed = SEED;
			for (int i = 0; i < 256; i++)
				regs[i[7:0]] <= 8'($random(seed));
			mode <= M_IDLE;
			bit_cnt <= 4'd0;
			shift <= 8'h00;
			ptr <= 8'h00;
			got_ptr <= 1'b0;
			rd <= 1'b0;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			o_sda_pull <= 1'b0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (scl_q && i_scl && sda_q && !i_sda) begin
				// start or repeated start
				mode <= M_ADDR;
				bit_cnt <= 4'd0;
				got_ptr <= 1'b0;
				o_sda_pull <= 1'b0;
			end else if (scl_q && i_scl && !sda_q && i_sda) begin
				mode <= M_IDLE;
				o_sda_pull <= 1'b0;
			end else if (!scl_q && i_scl) begin
				if ((mode == M_ADDR || mode == M_WRITE) && bit_cnt < 4'd8) begin
					shift <= {shift[6:0], i_sda};
					bit_cnt <= bit_cnt + 4'd1;
				end else if (mode == M_READ && bit_cnt == 4'd9) begin
					// master nack ends the read
					if (i_sda)
						mode <= M_IDLE;
					else
						bit_cnt <= 4'd0;
				end
			end else if (scl_q && !i_scl) begin
				if (mode == M_READ) begin
					if (bit_cnt < 4'd8) begin
						o_sda_pull <= !regs[ptr][3'd7 - bit_cnt[2:0]];
						bit_cnt <= bit_cnt + 4'd1;
					end else if (bit_cnt == 4'd8) begin
						o_sda_pull <= 1'b0;
						ptr <= ptr + 8'd1;
						bit_cnt <= 4'd9;
					end
				end else if (mode != M_IDLE && bit_cnt == 4'd8) begin
					// ack slot of a received byte
					bit_cnt <= 4'd9;
					if (mode == M_ADDR) begin
						if (shift[7:1] == DEV_ADDR && !i_absent) begin
							o_sda_pull <= 1'b1;
							rd <= shift[0];
						end else begin
							mode <= M_IDLE;
						end
					end else begin
						o_sda_pull <= 1'b1;
						if (got_ptr) begin
							regs[ptr] <= shift;
							ptr <= ptr + 8'd1;
						end else begin
							ptr <= shift;
							got_ptr <= 1'b1;
						end
					end
				end else if (mode != M_IDLE && bit_cnt == 4'd9) begin
					if (mode == M_ADDR && rd) begin
						// first read bit goes out right after the address ack
						mode <= M_READ;
						o_sda_pull <= !regs[ptr][7];
						bit_cnt <= 4'd1;
					end else begin
						mode <= M_WRITE;
						o_sda_pull <= 1'b0;
						bit_cnt <= 4'd0;
					end
				end
			end
		end
	end

endmodule

//--- verif/tb_adxl_i2c.sv
// adxl i2c master testbench
`timescale 1ns/1ps

module tb_adxl_i2c;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int SEED = 97363;
	localparam logic [7:0] TEST_REG = 8'h2C;

	logic clk;
	logic rst_n;
	logic start;
	adxl_i2c_pkg::op_t op;
	adxl_i2c_pkg::rate_t rate;
	logic [7:0] reg_addr;
	logic [7:0] w_data;
	logic drdy;
	logic absent;
	logic scl_oe;
	logic sda_oe;
	logic slave_pull;
	logic scl;
	logic sda;
	logic busy;
	logic done;
	logic nack;
	logic [7:0] reg_data;
	adxl_i2c_pkg::sample_t sample;
	logic [7:0] exp_regs [256];
	integer seed;

	// open-drain bus with pull-ups
	assign scl = !scl_oe;
	assign sda = !(sda_oe || slave_pull);

	adxl_i2c_top #(
		.DEV_ADDR (7'h1D)
	) i_adxl_i2c_top (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_start    (start),
		.i_op       (op),
		.i_rate     (rate),
		.i_reg_addr (reg_addr),
		.i_w_data   (w_data),
		.i_drdy     (drdy),
		.i_sda      (sda),
		.o_scl_oe   (scl_oe),
		.o_sda_oe   (sda_oe),
		.o_busy     (busy),
		.o_done     (done),
		.o_nack     (nack),
		.o_reg_data (reg_data),
		.o_sample   (sample)
	);

	adxl_slave_model #(
		.DEV_ADDR (7'h1D),
		.SEED     (SEED)
	) u_slave (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_scl      (scl),
		.i_sda      (sda),
		.i_absent   (absent),
		.o_sda_pull (slave_pull)
	);

	always #20 clk = ~clk;

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			$display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, got, expected);
			abort_run();
		end
	endtask

	task automatic check_sample(input logic [31:0] temp, input logic [31:0] accx,
		input logic [31:0] accy, input logic [31:0] accz);
		check_value("o_sample.temp", sample.temp, temp);
		check_value("o_sample.accx", sample.accx, accx);
		check_value("o_sample.accy", sample.accy, accy);
		check_value("o_sample.accz", sample.accz, accz);
	endtask

	// returns at the falling edge where o_done or o_busy is first seen high
	task automatic wait_for_flag(input logic want_done);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (want_done ? !done : !busy) begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout: o_%s never went high", want_done ? "done" : "busy");
				abort_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic start_cpu_op(input adxl_i2c_pkg::op_t cpu_op, input logic [7:0] addr,
		input logic [7:0] data);
		@(posedge clk);
		op <= cpu_op;
		reg_addr <= addr;
		w_data <= data;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// nine scl rises of the address byte, evenly spaced
	task automatic check_scl_period(input int period);
		int cycles;
		int gap;
		int rises;
		logic scl_prev;
		cycles = 0;
		gap = 0;
		rises = 0;
		scl_prev = scl;
		while (rises < 9) begin
			@(negedge clk);
			cycles++;
			gap++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout: scl stopped toggling during a byte");
				abort_run();
			end
			if (!scl_prev && scl) begin
				if (rises > 0)
					check_value("scl rise interval", 32'(gap), 32'(period));
				rises++;
				gap = 0;
			end
			scl_prev = scl;
		end
	endtask

	task automatic read_and_check(input logic [7:0] addr, input int period);
		start_cpu_op(adxl_i2c_pkg::OP_RREG, addr, 8'h00);
		if (period > 0)
			check_scl_period(period);
		wait_for_flag(1'b1);
		check_value("o_nack", 32'(nack), 32'd0);
		@(negedge clk);
		check_value("o_reg_data", 32'(reg_data), 32'(exp_regs[addr]));
	endtask

	// 20-bit axis value left-justified in three bytes
	function automatic logic [31:0] expected_axis(input logic [7:0] hi, input logic [7:0] mid,
		input logic [7:0] lo);
		return 32'($signed({hi, mid, lo[7:4], 12'h000}) >>> 12);
	endfunction

	initial begin
		logic [7:0] wdata;
		logic [7:0] addr;
		logic [7:0] prev;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		op = adxl_i2c_pkg::OP_RREG;
		rate = adxl_i2c_pkg::RATE_3125K;
		reg_addr = 8'h00;
		w_data = 8'h00;
		drdy = 1'b0;
		absent = 1'b0;
		seed = SEED;
		// same sequence the slave loads into its registers
		for (int i = 0; i < 256; i++)
			exp_regs[i[7:0]] = 8'($random(seed));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_value("o_busy", 32'(busy), 32'd0);
		check_value("o_done", 32'(done), 32'd0);
		check_value("o_nack", 32'(nack), 32'd0);
		check_value("o_scl_oe", 32'(scl_oe), 32'd0);
		check_value("o_sda_oe", 32'(sda_oe), 32'd0);
		check_sample(32'd0, 32'd0, 32'd0, 32'd0);

		// register write, then read it back
		wdata = 8'($random(seed));
		start_cpu_op(adxl_i2c_pkg::OP_WREG, TEST_REG, wdata);
		wait_for_flag(1'b1);
		check_value("o_nack", 32'(nack), 32'd0);
		exp_regs[TEST_REG] = wdata;
		read_and_check(TEST_REG, 0);

		addr = 8'($random(seed)) % 8'd48;
		read_and_check(addr, 0);

		// burst on data ready
		@(posedge clk);
		op <= adxl_i2c_pkg::OP_HW;
		drdy <= 1'b1;
		wait_for_flag(1'b0);
		@(posedge clk);
		drdy <= 1'b0;
		wait_for_flag(1'b1);
		check_value("o_nack", 32'(nack), 32'd0);
		@(negedge clk);
		check_sample({20'h00000, exp_regs[8'h06][3:0], exp_regs[8'h07]},
			expected_axis(exp_regs[8'h08], exp_regs[8'h09], exp_regs[8'h0A]),
			expected_axis(exp_regs[8'h0B], exp_regs[8'h0C], exp_regs[8'h0D]),
			expected_axis(exp_regs[8'h0E], exp_regs[8'h0F], exp_regs[8'h10]));

		// device that never acks its address
		prev = reg_data;
		@(posedge clk);
		absent <= 1'b1;
		start_cpu_op(adxl_i2c_pkg::OP_RREG, 8'h00, 8'h00);
		wait_for_flag(1'b1);
		check_value("o_nack", 32'(nack), 32'd1);
		@(negedge clk);
		check_value("o_reg_data", 32'(reg_data), 32'(prev));
		@(posedge clk);
		absent <= 1'b0;

		for (int r = 0; r < 4; r++) begin
			@(posedge clk);
			rate <= adxl_i2c_pkg::rate_t'(r[1:0]);
			addr = 8'($random(seed)) % 8'd48;
			read_and_check(addr, 1 << (r + 4));
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- compile.f
src/adxl_i2c_pkg.sv
src/i2c_bit_timer.sv
src/adxl_txn_sequencer.sv
src/i2c_byte_engine.sv
src/adxl_sample_assembler.sv
src/adxl_i2c_top.sv
verif/adxl_slave_model.sv
verif/tb_adxl_i2c.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_adxl_i2c -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_adxl_i2c
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
